// ==== tb.f ====
src/phs_avg_pkg.sv
src/gain_cmd_decode.sv
src/phs_avg_mul.sv
src/phs_avg.sv
src/phase_result.sv
src/phs_avg_top.sv
verification/phs_avg_properties.sv
verification/phs_avg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the phase averaging testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module phs_avg_tb -f tb.f -o sim_phs_avg

# the simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/sim_phs_avg > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

// ==== verification/phs_avg_tb.sv ====
`timescale 1ns/1ps

module phs_avg_tb;

	localparam int dwi = phs_avg_pkg::dwi_default;
	localparam int gw = phs_avg_pkg::gain_w;
	localparam int period = 100;
	localparam int reset_cycles = 5;
	localparam int unsigned seed = 32'h287a34e3;
	// pairs per test
	localparam int n_gain = 64;
	localparam int n_halt = 24;
	localparam int n_illegal = 24;
	localparam int n_ovf = 8;
	// two cycles per pair, plus commands, drains and reset
	localparam int watchdog_cycles = 2 * (n_gain + 2 * n_halt + n_illegal + n_ovf) + 200;
	localparam longint intg_max = (longint'(1) <<< (dwi + 3)) - 1;
	localparam logic signed [dwi-1:0] full_scale = {1'b0, {(dwi - 1){1'b1}}};

	logic clk;
	logic reset;
	logic iq;
	logic signed [dwi-1:0] x;
	logic signed [dwi-1:0] y;
	logic cmd_valid;
	phs_avg_pkg::cmd_op_t cmd_op;
	logic [gw-1:0] cmd_data;
	logic signed [dwi+1:0] phase_err;
	logic phase_valid;
	logic overflow;
	logic cmd_err;

	// reference model state
	logic signed [gw-1:0] m_kx_re;
	logic signed [gw-1:0] m_kx_im;
	logic signed [gw-1:0] m_ky_re;
	logic signed [gw-1:0] m_ky_im;
	logic m_run;
	logic m_clear;
	logic m_err;
	logic signed [gw-1:0] m_kx_d;
	logic signed [gw-1:0] m_ky_d;
	logic signed [dwi+1:0] m_xmr;
	logic signed [dwi+1:0] m_ymr;
	logic signed [dwi+2:0] m_sum;
	logic signed [dwi+3:0] m_intg;
	logic [2:0] m_iq_line;
	logic signed [dwi+1:0] m_phase_err;
	logic m_phase_valid;
	logic m_ovf;

	// edge number at which each pending result strobe is due
	int pend[$];
	int edge_count = 0;

	phs_avg_top #(
		.dwi(dwi)
	) UUT (
		.clk(clk),
		.reset(reset),
		.iq(iq),
		.x(x),
		.y(y),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_data(cmd_data),
		.phase_err(phase_err),
		.phase_valid(phase_valid),
		.overflow(overflow),
		.cmd_err(cmd_err)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	// sample times gain, lowest dwi-4 product bits dropped, dwi+2 bits kept
	function automatic logic signed [dwi+1:0] scale_product(
		input logic signed [dwi-1:0] s,
		input logic signed [gw-1:0] g
	);
		longint p;
		p = longint'(s) * longint'(g);
		p = p >>> (dwi - 4);
		return p[dwi+1:0];
	endfunction

	// cycle model, stages updated from the back so each reads its old input
	always @(posedge clk) begin : ref_model
		longint acc;
		if (reset) begin
			m_kx_re = '0;
			m_kx_im = '0;
			m_ky_re = '0;
			m_ky_im = '0;
			m_run = 1'b0;
			m_clear = 1'b0;
			m_err = 1'b0;
			m_kx_d = '0;
			m_ky_d = '0;
			m_xmr = '0;
			m_ymr = '0;
			m_sum = '0;
			m_intg = '0;
			m_iq_line = 3'b111;
			m_phase_err = '0;
			m_phase_valid = 1'b0;
			m_ovf = 1'b0;
		end else begin
			// result stage, imaginary half at the end of the iq line
			m_phase_valid = !m_iq_line[2];
			if (!m_iq_line[2])
				m_phase_err = m_intg[dwi+2:1];
			// integrator, clear beats the add
			if (m_clear) begin
				m_intg = '0;
				m_ovf = 1'b0;
			end else if (m_run) begin
				acc = longint'(m_intg) + longint'(m_sum);
				if (acc > intg_max || acc < -intg_max - 1)
					m_ovf = 1'b1;
				m_intg = acc[dwi+3:0];
			end
			acc = longint'(m_xmr) + longint'(m_ymr);
			m_sum = acc[dwi+2:0];
			// product uses the gain picked one sample earlier
			m_xmr = scale_product(x, m_kx_d);
			m_ymr = scale_product(y, m_ky_d);
			m_kx_d = iq ? m_kx_re : m_kx_im;
			m_ky_d = iq ? m_ky_re : m_ky_im;
			m_iq_line = {m_iq_line[1:0], iq};
			m_clear = 1'b0;
			m_err = 1'b0;
			if (cmd_valid) begin
				case (cmd_op)
					phs_avg_pkg::cmd_kx_re: m_kx_re = cmd_data;
					phs_avg_pkg::cmd_kx_im: m_kx_im = cmd_data;
					phs_avg_pkg::cmd_ky_re: m_ky_re = cmd_data;
					phs_avg_pkg::cmd_ky_im: m_ky_im = cmd_data;
					phs_avg_pkg::cmd_clear: m_clear = 1'b1;
					phs_avg_pkg::cmd_run: m_run = 1'b1;
					phs_avg_pkg::cmd_halt: m_run = 1'b0;
					default: m_err = 1'b1;
				endcase
			end
		end
	end

	task automatic check_value(input string name, input longint actual, input longint expected);
		if (actual != expected) begin
			$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_error(input string what);
		$display("[ERROR] t=%0t %s", $time, what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	task automatic compare_outputs();
		check_value("phase_err", phase_err, m_phase_err);
		check_value("phase_valid", phase_valid, m_phase_valid);
		check_value("overflow", overflow, m_ovf);
		check_value("cmd_err", cmd_err, m_err);
		if (phase_valid) begin
			if (pend.size() == 0)
				report_error("phase_valid pulsed with no imaginary sample in flight");
			else
				check_value("phase_valid edge", edge_count, pend.pop_front());
		end else if (pend.size() != 0 && pend[0] <= edge_count) begin
			report_error("phase_valid missing four edges after an imaginary sample");
		end
	endtask

	// drive one cycle at the rising edge, compare at the falling edge
	task automatic cycle_step(
		input logic iq_v,
		input logic signed [dwi-1:0] x_v,
		input logic signed [dwi-1:0] y_v,
		input logic cv,
		input phs_avg_pkg::cmd_op_t op,
		input logic [gw-1:0] data
	);
		@(posedge clk);
		// edge_count still shows the previous edge here
		if (!iq_v)
			pend.push_back(edge_count + 5);
		iq <= iq_v;
		x <= x_v;
		y <= y_v;
		cmd_valid <= cv;
		cmd_op <= op;
		cmd_data <= data;
		@(negedge clk);
		compare_outputs();
	endtask

	// idle keeps iq high so no result strobes are produced
	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			cycle_step(1'b1, '0, '0, 1'b0, phs_avg_pkg::cmd_kx_re, '0);
	endtask

	task automatic send_cmd(input phs_avg_pkg::cmd_op_t op, input logic [gw-1:0] data);
		cycle_step(1'b1, '0, '0, 1'b1, op, data);
	endtask

	task automatic send_pair(input logic signed [dwi-1:0] xr, xi, yr, yi);
		// real half first
		cycle_step(1'b1, xr, yr, 1'b0, phs_avg_pkg::cmd_kx_re, '0);
		cycle_step(1'b0, xi, yi, 1'b0, phs_avg_pkg::cmd_kx_re, '0);
	endtask

	function automatic logic signed [dwi-1:0] rand_sample();
		logic [31:0] r;
		r = $urandom;
		return r[dwi-1:0];
	endfunction

	task automatic random_pairs(input int n);
		for (int i = 0; i < n; i++)
			send_pair(rand_sample(), rand_sample(), rand_sample(), rand_sample());
	endtask

	task automatic write_gains(input logic [gw-1:0] xr, xi, yr, yi);
		send_cmd(phs_avg_pkg::cmd_kx_re, xr);
		send_cmd(phs_avg_pkg::cmd_kx_im, xi);
		send_cmd(phs_avg_pkg::cmd_ky_re, yr);
		send_cmd(phs_avg_pkg::cmd_ky_im, yi);
	endtask

	task automatic test_reset_state();
		check_value("phase_valid after reset", phase_valid, 0);
		check_value("overflow after reset", overflow, 0);
		check_value("cmd_err after reset", cmd_err, 0);
		check_value("phase_err after reset", phase_err, 0);
	endtask

	task automatic test_gain_product();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = $urandom;
		r1 = $urandom;
		write_gains(r0[15:0], r0[31:16], r1[15:0], r1[31:16]);
		send_cmd(phs_avg_pkg::cmd_run, '0);
		random_pairs(n_gain);
		idle(6);
	endtask

	task automatic test_halt_clear();
		logic signed [dwi+1:0] frozen;
		random_pairs(4);
		send_cmd(phs_avg_pkg::cmd_halt, '0);
		idle(6);
		// integrator stopped, every later pair reports this z
		frozen = m_intg[dwi+2:1];
		for (int i = 0; i < n_halt; i++) begin
			send_pair(rand_sample(), rand_sample(), rand_sample(), rand_sample());
			check_value("phase_err while halted", phase_err, frozen);
		end
		send_cmd(phs_avg_pkg::cmd_clear, '0);
		idle(2);
		send_pair('0, '0, '0, '0);
		idle(5);
		check_value("phase_err after clear", phase_err, 0);
		send_cmd(phs_avg_pkg::cmd_run, '0);
		random_pairs(n_halt);
		idle(6);
	endtask

	task automatic test_illegal_op();
		send_cmd(phs_avg_pkg::cmd_op_t'(3'd7), 16'hffff);
		// error pulse one edge after the strobe, for one cycle
		idle(1);
		check_value("cmd_err on code 7", cmd_err, 1);
		idle(1);
		check_value("cmd_err after pulse", cmd_err, 0);
		random_pairs(n_illegal);
		idle(6);
	endtask

	task automatic test_overflow();
		bit wrapped;
		wrapped = 1'b0;
		write_gains(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
		send_cmd(phs_avg_pkg::cmd_clear, '0);
		send_cmd(phs_avg_pkg::cmd_run, '0);
		for (int i = 0; i < 2 * n_ovf && !wrapped; i++) begin
			cycle_step((i % 2) == 0, full_scale, full_scale, 1'b0,
				phs_avg_pkg::cmd_kx_re, '0);
			// all addends positive, a negative z means the add wrapped
			if (m_intg < 0) begin
				wrapped = 1'b1;
				check_value("overflow at wrap", overflow, 1);
			end else begin
				check_value("overflow before wrap", overflow, 0);
			end
		end
		if (!wrapped)
			report_error("integrator never wrapped with full-scale inputs");
		for (int i = 0; i < 4; i++) begin
			idle(1);
			check_value("overflow held", overflow, 1);
		end
		send_cmd(phs_avg_pkg::cmd_clear, '0);
		idle(1);
		check_value("overflow before clear edge", overflow, 1);
		idle(1);
		check_value("overflow after clear", overflow, 0);
	endtask

	initial begin
		#(longint'(watchdog_cycles) * period);
		$display("timeout: tests still running after %0d clock cycles", watchdog_cycles);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(seed));
		reset = 1'b1;
		iq = 1'b1;
		x = '0;
		y = '0;
		cmd_valid = 1'b0;
		cmd_op = phs_avg_pkg::cmd_kx_re;
		cmd_data = '0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		test_reset_state();
		test_gain_product();
		test_halt_clear();
		test_illegal_op();
		test_overflow();
		idle(6);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== verification/phs_avg_properties.sv ====
`timescale 1ns/1ps

module phs_avg_properties (
	input logic clk,
	input logic reset,
	input logic iq_d,
	input logic phase_valid,
	input logic cmd_err,
	input logic run,
	input logic overflow,
	input logic intg_clear
);

	// result strobe only after the imaginary half reached iq_d
	valid_after_pair: assert property (
		@(posedge clk) disable iff (reset)
		phase_valid |-> !$past(iq_d)
	) else $error("phase_valid without a completed pair");

	// illegal code leaves the run flag alone
	err_keeps_run: assert property (
		@(posedge clk) disable iff (reset)
		cmd_err |-> (run == $past(run))
	) else $error("run changed together with cmd_err");

	// sticky flag, only a clear pulse drops it
	overflow_sticky: assert property (
		@(posedge clk) disable iff (reset)
		(!overflow && $past(overflow)) |-> $past(intg_clear)
	) else $error("overflow fell without intg_clear");

endmodule

bind phs_avg_top phs_avg_properties props (
	.clk(clk),
	.reset(reset),
	.iq_d(iq_d),
	.phase_valid(phase_valid),
	.cmd_err(cmd_err),
	.run(run),
	.overflow(overflow),
	.intg_clear(intg_clear)
);

// ==== src/phs_avg_top.sv ====
`timescale 1ns/1ps

module phs_avg_top #(
	parameter int dwi = phs_avg_pkg::dwi_default
) (
	input logic clk,
	input logic reset,
	// interleaved samples, iq high on the real half
	input logic iq,
	input logic signed [dwi-1:0] x,
	input logic signed [dwi-1:0] y,
	// host write port
	input logic cmd_valid,
	input phs_avg_pkg::cmd_op_t cmd_op,
	input logic [phs_avg_pkg::gain_w-1:0] cmd_data,
	// results
	output logic signed [dwi+1:0] phase_err,
	output logic phase_valid,
	output logic overflow,
	output logic cmd_err
);

	// decoder to execute
	logic signed [phs_avg_pkg::gain_w-1:0] kx;
	logic signed [phs_avg_pkg::gain_w-1:0] ky;
	logic kx_addr;
	logic ky_addr;
	logic run;
	logic intg_clear;
	// execute to result
	logic signed [dwi+1:0] z;
	logic iq_d;
	logic intg_wrap;

	gain_cmd_decode decode (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_data(cmd_data),
		.kx_addr(kx_addr),
		.ky_addr(ky_addr),
		.kx(kx),
		.ky(ky),
		.run(run),
		.intg_clear(intg_clear),
		.cmd_err(cmd_err)
	);

	phs_avg #(
		.dwi(dwi)
	) execute (
		.clk(clk),
		.reset(reset),
		.iq(iq),
		.x(x),
		.y(y),
		.kx(kx),
		.ky(ky),
		.kx_addr(kx_addr),
		.ky_addr(ky_addr),
		.run(run),
		.intg_clear(intg_clear),
		.z(z),
		.iq_d(iq_d),
		.intg_wrap(intg_wrap)
	);

	phase_result #(
		.dwi(dwi)
	) result (
		.clk(clk),
		.reset(reset),
		.z(z),
		.iq_d(iq_d),
		.intg_wrap(intg_wrap),
		.intg_clear(intg_clear),
		.phase_err(phase_err),
		.phase_valid(phase_valid),
		.overflow(overflow)
	);

endmodule

// ==== src/phase_result.sv ====
`timescale 1ns/1ps

module phase_result #(
	parameter int dwi = phs_avg_pkg::dwi_default
) (
	input logic clk,
	input logic reset,
	input logic signed [dwi+1:0] z,
	input logic iq_d,
	input logic intg_wrap,
	input logic intg_clear,
	output logic signed [dwi+1:0] phase_err,
	output logic phase_valid,
	output logic overflow
);

	// a pair is complete once its imaginary half has been integrated,
	// iq_d low marks that cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			phase_err <= '0;
			phase_valid <= 1'b0;
		end else begin
			phase_valid <= !iq_d;
			// hold the last sample between pairs
			if (!iq_d) begin
				phase_err <= z;
			end
		end
	end

	// sticky overflow
	// wrap pulse comes one cycle ahead of the wrapped integrator,
	// so the flag rises together with the wrapped z
	// clear has priority, the execute stage masks wrap during clear too
	always_ff @(posedge clk) begin
		if (reset) begin
			overflow <= 1'b0;
		end else if (intg_clear) begin
			overflow <= 1'b0;
		end else if (intg_wrap) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== src/phs_avg.sv ====
`timescale 1ns/1ps

module phs_avg #(
	parameter int dwi = phs_avg_pkg::dwi_default
) (
	input logic clk,
	input logic reset,
	input logic iq,
	input logic signed [dwi-1:0] x,
	input logic signed [dwi-1:0] y,
	input logic signed [phs_avg_pkg::gain_w-1:0] kx,
	input logic signed [phs_avg_pkg::gain_w-1:0] ky,
	output logic kx_addr,
	output logic ky_addr,
	input logic run,
	input logic intg_clear,
	output logic signed [dwi+1:0] z,
	output logic iq_d,
	output logic intg_wrap
);

	// products of forward and reverse paths
	logic signed [dwi+1:0] xmr;
	logic signed [dwi+1:0] ymr;
	// pair sum, one bit of growth over a product
	logic signed [dwi+2:0] sum;
	// integrator and its next value
	logic signed [dwi+3:0] intg;
	logic signed [dwi+3:0] intg_next;
	// iq line, matches the three register stages to the integrator
	logic [2:0] iq_pipe;

	// gain address follows the sample flag directly
	assign kx_addr = iq;
	assign ky_addr = iq;

	// forward path
	phs_avg_mul #(
		.dwi(dwi)
	) xmul (
		.clk(clk),
		.reset(reset),
		.x(x),
		.k(kx),
		.z(xmr)
	);

	// reverse path
	phs_avg_mul #(
		.dwi(dwi)
	) ymul (
		.clk(clk),
		.reset(reset),
		.x(y),
		.k(ky),
		.z(ymr)
	);

	assign intg_next = intg + sum;

	// sum lands two edges after the sample, the integrator one edge later
	// clear wins over the add
	always_ff @(posedge clk) begin
		if (reset) begin
			sum <= '0;
			intg <= '0;
			iq_pipe <= 3'b111;
		end else begin
			sum <= xmr + ymr;
			iq_pipe <= {iq_pipe[1:0], iq};
			if (intg_clear) begin
				intg <= '0;
			end else if (run) begin
				intg <= intg_next;
			end
		end
	end

	// signed wrap of the integrator
	// addends agree in sign but the result does not
	// high in the cycle before the wrapped value is stored
	assign intg_wrap = run && !intg_clear
		&& (intg[dwi+3] == sum[dwi+2])
		&& (intg_next[dwi+3] != intg[dwi+3]);

	// drop the integrator sign-extension bit and the lsb
	assign z = intg[dwi+2:1];
	assign iq_d = iq_pipe[2];

endmodule

// ==== src/phs_avg_mul.sv ====
`timescale 1ns/1ps

module phs_avg_mul #(
	parameter int dwi = phs_avg_pkg::dwi_default
) (
	input logic clk,
	input logic reset,
	input logic signed [dwi-1:0] x,
	input logic signed [phs_avg_pkg::gain_w-1:0] k,
	output logic signed [dwi+1:0] z
);

	// full product width
	localparam int pw = dwi + phs_avg_pkg::gain_w;

	// gain held back by one sample
	logic signed [phs_avg_pkg::gain_w-1:0] k_d;
	logic signed [pw-1:0] prod;

	// gain is registered once before the multiply
	// with iq alternating, a real x meets the imaginary gain
	// and an imaginary x meets the real gain, which is all the
	// imaginary part of the complex product needs
	always_ff @(posedge clk) begin
		if (reset) begin
			k_d <= '0;
			prod <= '0;
		end else begin
			k_d <= k;
			prod <= x * k_d;
		end
	end

	// drop the redundant sign bit on top and gain_w-3 fraction bits
	// at the bottom, leaving dwi+2 bits
	assign z = prod[pw-2:phs_avg_pkg::gain_w-3];

endmodule

// ==== src/gain_cmd_decode.sv ====
`timescale 1ns/1ps

module gain_cmd_decode (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input phs_avg_pkg::cmd_op_t cmd_op,
	input logic [phs_avg_pkg::gain_w-1:0] cmd_data,
	input logic kx_addr,
	input logic ky_addr,
	output logic signed [phs_avg_pkg::gain_w-1:0] kx,
	output logic signed [phs_avg_pkg::gain_w-1:0] ky,
	output logic run,
	output logic intg_clear,
	output logic cmd_err
);

	// gain bank, one word per real/imaginary part of each gain
	logic signed [phs_avg_pkg::gain_w-1:0] kx_re;
	logic signed [phs_avg_pkg::gain_w-1:0] kx_im;
	logic signed [phs_avg_pkg::gain_w-1:0] ky_re;
	logic signed [phs_avg_pkg::gain_w-1:0] ky_im;

	// command decode
	// every strobe is acted on in the cycle it arrives,
	// the effect shows from the following edge on
	always_ff @(posedge clk) begin
		if (reset) begin
			kx_re <= '0;
			kx_im <= '0;
			ky_re <= '0;
			ky_im <= '0;
			run <= 1'b0;
			intg_clear <= 1'b0;
			cmd_err <= 1'b0;
		end else begin
			// both pulses last a single cycle
			intg_clear <= 1'b0;
			cmd_err <= 1'b0;
			if (cmd_valid) begin
				case (cmd_op)
					phs_avg_pkg::cmd_kx_re: begin
						kx_re <= cmd_data;
					end
					phs_avg_pkg::cmd_kx_im: begin
						kx_im <= cmd_data;
					end
					phs_avg_pkg::cmd_ky_re: begin
						ky_re <= cmd_data;
					end
					phs_avg_pkg::cmd_ky_im: begin
						ky_im <= cmd_data;
					end
					phs_avg_pkg::cmd_clear: begin
						// integrator and overflow flag zero on the next edge
						intg_clear <= 1'b1;
					end
					phs_avg_pkg::cmd_run: begin
						run <= 1'b1;
					end
					phs_avg_pkg::cmd_halt: begin
						run <= 1'b0;
					end
					default: begin
						// unknown code, gains and run stay as they are
						cmd_err <= 1'b1;
					end
				endcase
			end
		end
	end

	// read-out muxes for the execute stage
	// address 1 picks the real part, address 0 the imaginary part
	always_comb begin
		if (kx_addr) begin
			kx = kx_re;
		end else begin
			kx = kx_im;
		end
	end

	always_comb begin
		if (ky_addr) begin
			ky = ky_re;
		end else begin
			ky = ky_im;
		end
	end

endmodule

// ==== src/phs_avg_pkg.sv ====
package phs_avg_pkg;

	// width of every gain word in the bank
	// the multiplier product slice is tied to this value,
	// so it is a constant and not a module parameter
	localparam int gain_w = 16;

	// sample width used when the top level is left at its default
	// any width from 12 to 24 is supported by the datapath
	localparam int dwi_default = 17;

	// host command opcodes, 3 bits on the command port
	// an idle host simply keeps cmd_valid low, so there is no nop code
	// code 7 carries no command and is reported through cmd_err
	typedef enum logic [2:0] {
		// forward gain, real part (read at address 1)
		cmd_kx_re = 3'd0,
		// forward gain, imaginary part (read at address 0)
		cmd_kx_im = 3'd1,
		// reverse gain, real part (read at address 1)
		cmd_ky_re = 3'd2,
		// reverse gain, imaginary part (read at address 0)
		cmd_ky_im = 3'd3,
		// zero the integrator and the sticky overflow flag
		cmd_clear = 3'd4,
		// start integrating
		cmd_run = 3'd5,
		// freeze the integrator at its present value
		cmd_halt = 3'd6
	} cmd_op_t;

endpackage
